//--- sources.f
core_pkg.sv
core_ifu.sv
core_idu.sv
core_regfile.sv
core_exu.sv
core_wbu.sv
core_top.sv
core_chk.sv
core_tb.sv

//--- run.sh
#!/bin/bash
# Build and run with Verilator, fail if the log reports errors
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module core_tb -f sources.f \
  > sim.log 2>&1 && ./obj_dir/Vcore_tb >> sim.log 2>&1
cat sim.log
! grep -q "ERRORS FOUND" sim.log && grep -q "NO ERRORS" sim.log && exit 0 || exit 1

//--- core_tb.sv
`timescale 1ns/1ps
`default_nettype none

module core_tb;

  typedef struct packed {
    core_pkg::inst_t    inst;
    core_pkg::word_t    pc;
    logic               commit;
    logic               wr;
    core_pkg::reg_idx_t rd;
    core_pkg::word_t    data;
    core_pkg::word_t    npc;
    logic               halt;
    logic               invalid;
  } row_s;

  logic              clk_i;
  logic              rst_i;
  logic              inst_valid_i;
  core_pkg::inst_t   inst_i;
  core_pkg::word_t   pc_o;
  logic              halted_o;
  core_pkg::commit_s commit_o;

  row_s  tbl[$];
  string names[$];
  int    errors;
  int    row_errs;
  int    tests;
  int    commit_cnt;
  int    seed;

  core_top i_core_top (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .inst_valid_i (inst_valid_i),
    .inst_i       (inst_i),
    .pc_o         (pc_o),
    .halted_o     (halted_o),
    .commit_o     (commit_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  // Count every commit to catch commits after a halt
  always @(negedge clk_i) begin
    if (!rst_i && commit_o.valid) begin
      commit_cnt++;
    end
  end

  // Instruction encoders
  function automatic core_pkg::inst_t enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                            input logic [4:0] rs1, input logic [2:0] f3,
                                            input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic core_pkg::inst_t enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                            input logic [2:0] f3, input logic [4:0] rd,
                                            input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic core_pkg::inst_t enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                            input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
  endfunction

  function automatic core_pkg::inst_t enc_j(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
  endfunction

  function automatic core_pkg::word_t sext12(input logic [11:0] imm);
    return {{52{imm[11]}}, imm};
  endfunction

  task automatic add_row(input string name, input core_pkg::inst_t inst,
                         input core_pkg::word_t pc, input logic commit, input logic wr,
                         input logic [4:0] rd, input core_pkg::word_t data,
                         input core_pkg::word_t npc, input logic halt, input logic inv);
    row_s r;
    r = '{inst, pc, commit, wr, rd, data, npc, halt, inv};
    tbl.push_back(r);
    names.push_back(name);
  endtask

  task automatic build_table();
    logic [11:0]     ia;
    logic [11:0]     ib;
    logic [11:0]     ic;
    core_pkg::word_t x1;
    core_pkg::word_t x2;
    seed = 71;
    ia = $random(seed);
    ib = $random(seed);
    ic = $random(seed);
    x1 = sext12(ia);
    x2 = sext12(ib);
    // Phase one covers straight line code, branches, jumps and EBREAK
    add_row("addi_x1", enc_i(ia, 0, 3'b000, 1, 7'b0010011), 0, 1, 1, 1, x1, 4, 0, 0);
    add_row("addi_x2", enc_i(ib, 0, 3'b000, 2, 7'b0010011), 4, 1, 1, 2, x2, 8, 0, 0);
    add_row("add", enc_r(7'h00, 2, 1, 3'b000, 3), 8, 1, 1, 3, x1 + x2, 12, 0, 0);
    add_row("sub", enc_r(7'h20, 2, 1, 3'b000, 4), 12, 1, 1, 4, x1 - x2, 16, 0, 0);
    add_row("xori", enc_i(ic, 1, 3'b100, 5, 7'b0010011), 16, 1, 1, 5, x1 ^ sext12(ic),
            20, 0, 0);
    add_row("or", enc_r(7'h00, 2, 1, 3'b110, 6), 20, 1, 1, 6, x1 | x2, 24, 0, 0);
    add_row("and", enc_r(7'h00, 2, 1, 3'b111, 7), 24, 1, 1, 7, x1 & x2, 28, 0, 0);
    add_row("addi_neg", enc_i(12'hff0, 0, 3'b000, 8, 7'b0010011), 28, 1, 1, 8,
            64'hffff_ffff_ffff_fff0, 32, 0, 0);
    add_row("srai", enc_i({6'b010000, 6'd2}, 8, 3'b101, 9, 7'b0010011), 32, 1, 1, 9,
            64'hffff_ffff_ffff_fffc, 36, 0, 0);
    add_row("srli", enc_i({6'b000000, 6'd60}, 8, 3'b101, 10, 7'b0010011), 36, 1, 1, 10,
            64'hf, 40, 0, 0);
    add_row("slli", enc_i({6'b000000, 6'd33}, 10, 3'b001, 11, 7'b0010011), 40, 1, 1, 11,
            64'h1e_0000_0000, 44, 0, 0);
    add_row("sra", enc_r(7'h20, 10, 8, 3'b101, 12), 44, 1, 1, 12, '1, 48, 0, 0);
    add_row("slt", enc_r(7'h00, 10, 8, 3'b010, 13), 48, 1, 1, 13, 1, 52, 0, 0);
    add_row("sltu", enc_r(7'h00, 10, 8, 3'b011, 14), 52, 1, 1, 14, 0, 56, 0, 0);
    add_row("sltiu", enc_i(12'd16, 10, 3'b011, 15, 7'b0010011), 56, 1, 1, 15, 1, 60, 0, 0);
    add_row("lui", {20'h80000, 5'd16, 7'b0110111}, 60, 1, 1, 16,
            64'hffff_ffff_8000_0000, 64, 0, 0);
    add_row("auipc", {20'h00001, 5'd17, 7'b0010111}, 64, 1, 1, 17, 64'h1040, 68, 0, 0);
    add_row("addi_x0", enc_i(12'd5, 1, 3'b000, 0, 7'b0010011), 68, 1, 0, 0, 0, 72, 0, 0);
    add_row("read_x0", enc_r(7'h00, 10, 0, 3'b000, 18), 72, 1, 1, 18, 15, 76, 0, 0);
    add_row("beq_taken", enc_b(13'd8, 10, 10, 3'b000), 76, 1, 0, 0, 0, 84, 0, 0);
    add_row("bne_untaken", enc_b(13'd8, 10, 10, 3'b001), 84, 1, 0, 0, 0, 88, 0, 0);
    add_row("blt_taken", enc_b(13'd8, 10, 8, 3'b100), 88, 1, 0, 0, 0, 96, 0, 0);
    add_row("bge_untaken", enc_b(13'd8, 10, 8, 3'b101), 96, 1, 0, 0, 0, 100, 0, 0);
    add_row("bltu_untaken", enc_b(13'd8, 10, 8, 3'b110), 100, 1, 0, 0, 0, 104, 0, 0);
    add_row("bgeu_taken", enc_b(13'd8, 10, 8, 3'b111), 104, 1, 0, 0, 0, 112, 0, 0);
    add_row("jal", enc_j(21'd16, 19), 112, 1, 1, 19, 116, 128, 0, 0);
    add_row("jalr", enc_i(12'd5, 19, 3'b000, 20, 7'b1100111), 128, 1, 1, 20, 132, 120, 0, 0);
    add_row("add_links", enc_r(7'h00, 20, 19, 3'b000, 21), 120, 1, 1, 21, 248, 124, 0, 0);
    add_row("ebreak", core_pkg::EBREAK_INST, 124, 1, 0, 0, 0, 128, 1, 0);
    add_row("after_halt", enc_i(12'd1, 0, 3'b000, 1, 7'b0010011), 128, 0, 0, 0, 0, 0, 0, 0);
    add_row("strobe_halted", enc_i(12'd2, 0, 3'b000, 1, 7'b0010011), 128, 0, 0, 0, 0, 0, 0, 0);
    // Phase two after a fresh reset
    add_row("addi_reset", enc_i(12'd3, 0, 3'b000, 1, 7'b0010011), 0, 1, 1, 1, 3, 4, 0, 0);
    add_row("regs_cleared", enc_r(7'h00, 5, 1, 3'b000, 2), 4, 1, 1, 2, 3, 8, 0, 0);
    add_row("load_invalid", enc_i(12'd0, 1, 3'b011, 3, 7'b0000011), 8, 1, 0, 0, 0, 12, 0, 1);
    add_row("after_invalid", enc_i(12'd1, 0, 3'b000, 1, 7'b0010011), 12, 0, 0, 0, 0, 0, 0, 0);
  endtask

  task automatic check_field(input string test, input string field,
                             input logic [63:0] exp, input logic [63:0] act);
    if (exp !== act) begin
      errors++;
      row_errs++;
      $display("[FAIL] %s %s expected %h actual %h", test, field, exp, act);
    end
  endtask

  task automatic apply_reset();
    @(posedge clk_i);
    rst_i        <= 1'b1;
    inst_valid_i <= 1'b0;
    repeat (3) @(posedge clk_i);
    rst_i <= 1'b0;
  endtask

  task automatic drive_rows(input int lo, input int hi);
    for (int i = lo; i < hi; i++) begin
      @(posedge clk_i);
      inst_valid_i <= 1'b1;
      inst_i       <= tbl[i].inst;
      // pc_o now holds the pc this word will be latched with
      @(negedge clk_i);
      if (pc_o !== tbl[i].pc) begin
        errors++;
        $display("[FAIL] %s pc_o expected %h actual %h", names[i], tbl[i].pc, pc_o);
      end
    end
    @(posedge clk_i);
    inst_valid_i <= 1'b0;
  endtask

  task automatic collect_commits(input int lo, input int hi);
    logic got;
    for (int i = lo; i < hi; i++) begin
      if (tbl[i].commit) begin
        got = 1'b0;
        while (!got) begin
          @(negedge clk_i);
          got = commit_o.valid;
        end
        row_errs = 0;
        tests++;
        check_field(names[i], "pc", tbl[i].pc, commit_o.pc);
        check_field(names[i], "rd_wr_en", tbl[i].wr, commit_o.rd_wr_en);
        if (tbl[i].wr) begin
          check_field(names[i], "rd_idx", tbl[i].rd, commit_o.rd_idx);
          check_field(names[i], "rd_data", tbl[i].data, commit_o.rd_data);
        end
        check_field(names[i], "next_pc", tbl[i].npc, commit_o.next_pc);
        check_field(names[i], "halt", tbl[i].halt, commit_o.halt);
        check_field(names[i], "invalid", tbl[i].invalid, commit_o.invalid);
        if (row_errs == 0) begin
          $display("[PASS] %s", names[i]);
        end
      end
    end
  endtask

  task automatic run_phase(input int lo, input int hi);
    int start_cnt;
    int expected;
    apply_reset();
    start_cnt = commit_cnt;
    expected  = 0;
    for (int i = lo; i < hi; i++) begin
      expected += tbl[i].commit;
    end
    fork
      drive_rows(lo, hi);
      collect_commits(lo, hi);
    join
    repeat (3) @(negedge clk_i);
    tests++;
    if (commit_cnt - start_cnt != expected) begin
      errors++;
      $display("Core committed %0d instructions where %0d were expected",
               commit_cnt - start_cnt, expected);
    end else if (!halted_o) begin
      errors++;
      $display("Core is not halted at the end of the trace");
    end else begin
      $display("[PASS] halt holds, later strobe ignored");
    end
  endtask

  initial begin
    int timeout_ns;
    rst_i        = 1'b1;
    inst_valid_i = 1'b0;
    inst_i       = '0;
    errors       = 0;
    tests        = 0;
    commit_cnt   = 0;
    build_table();
    timeout_ns = (tbl.size() + 20) * 4;
    fork
      begin
        #(timeout_ns);
        $display("Watchdog expired before the trace completed");
        $display("ERRORS FOUND");
        $finish;
      end
    join_none
    run_phase(0, 31);
    run_phase(31, tbl.size());
    $display("Tests run %0d, errors %0d", tests, errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- core_chk.sv
`timescale 1ns/1ps
`default_nettype none

module core_chk (
  input logic              clk_i,
  input logic              rst_i,
  input logic              accept_i,
  input logic              wr_en_i,
  input logic              halted_i,
  input core_pkg::commit_s commit_i
);

  // Accepted strobe commits two edges later
  a_commit_latency: assert property (@(posedge clk_i) disable iff (rst_i)
    accept_i |-> ##2 commit_i.valid)
    else $error("commit missing two cycles after accept");

  a_commit_source: assert property (@(posedge clk_i) disable iff (rst_i)
    commit_i.valid |-> $past(accept_i, 2))
    else $error("commit without an accepted strobe");

  a_no_write_halted: assert property (@(posedge clk_i) disable iff (rst_i)
    halted_i |-> !wr_en_i)
    else $error("register write while halted");

  // Only reset releases the halt
  a_halt_sticky: assert property (@(posedge clk_i)
    $fell(halted_i) |-> $past(rst_i))
    else $error("halted dropped without reset");

endmodule

bind core_top core_chk i_core_chk (
  .clk_i    (clk_i),
  .rst_i    (rst_i),
  .accept_i (i_core_ifu.accept),
  .wr_en_i  (wr_en),
  .halted_i (halted_o),
  .commit_i (commit_o)
);

`default_nettype wire

//--- core_top.sv
`timescale 1ns/1ps
`default_nettype none

module core_top #(
  parameter core_pkg::word_t RESET_PC = '0
) (
  input  logic              clk_i,
  input  logic              rst_i,
  input  logic              inst_valid_i,
  input  core_pkg::inst_t   inst_i,
  output core_pkg::word_t   pc_o,
  output logic              halted_o,
  output core_pkg::commit_s commit_o
);

  core_pkg::fetch_s   fetch;
  core_pkg::dec_s     dec;
  core_pkg::reg_idx_t rs1_idx, rs2_idx;
  logic               rs1_read_en, rs2_read_en;
  core_pkg::word_t    rs1_data, rs2_data;
  logic               exe_valid, halt_req;
  core_pkg::word_t    result, next_pc;
  logic               exe_rd_wr_en;
  core_pkg::reg_idx_t exe_rd_idx;
  logic               wr_en;
  core_pkg::reg_idx_t wr_idx;
  core_pkg::word_t    wr_data;

  core_ifu #(
    .RESET_PC (RESET_PC)
  ) i_core_ifu (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .inst_valid_i (inst_valid_i),
    .inst_i       (inst_i),
    .exe_valid_i  (exe_valid),
    .next_pc_i    (next_pc),
    .halt_req_i   (halt_req),
    .fetch_o      (fetch),
    .pc_o         (pc_o),
    .halted_o     (halted_o)
  );

  core_idu i_core_idu (
    .fetch_i       (fetch),
    .rs1_data_i    (rs1_data),
    .rs2_data_i    (rs2_data),
    .rs1_idx_o     (rs1_idx),
    .rs2_idx_o     (rs2_idx),
    .rs1_read_en_o (rs1_read_en),
    .rs2_read_en_o (rs2_read_en),
    .dec_o         (dec)
  );

  core_regfile i_core_regfile (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .rs1_idx_i     (rs1_idx),
    .rs2_idx_i     (rs2_idx),
    .rs1_read_en_i (rs1_read_en),
    .rs2_read_en_i (rs2_read_en),
    .wr_en_i       (wr_en),
    .wr_idx_i      (wr_idx),
    .wr_data_i     (wr_data),
    .rs1_data_o    (rs1_data),
    .rs2_data_o    (rs2_data)
  );

  core_exu i_core_exu (
    .fetch_i     (fetch),
    .dec_i       (dec),
    .exe_valid_o (exe_valid),
    .result_o    (result),
    .next_pc_o   (next_pc),
    .halt_req_o  (halt_req),
    .rd_wr_en_o  (exe_rd_wr_en),
    .rd_idx_o    (exe_rd_idx)
  );

  core_wbu i_core_wbu (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .exe_valid_i (exe_valid),
    .pc_i        (fetch.pc),
    .rd_wr_en_i  (exe_rd_wr_en),
    .rd_idx_i    (exe_rd_idx),
    .result_i    (result),
    .next_pc_i   (next_pc),
    .halt_req_i  (halt_req),
    .invalid_i   (dec.invalid),
    .wr_en_o     (wr_en),
    .wr_idx_o    (wr_idx),
    .wr_data_o   (wr_data),
    .commit_o    (commit_o)
  );

endmodule

`default_nettype wire

//--- core_wbu.sv
`timescale 1ns/1ps
`default_nettype none

module core_wbu (
  input  logic               clk_i,
  input  logic               rst_i,
  input  logic               exe_valid_i,
  input  core_pkg::word_t    pc_i,
  input  logic               rd_wr_en_i,
  input  core_pkg::reg_idx_t rd_idx_i,
  input  core_pkg::word_t    result_i,
  input  core_pkg::word_t    next_pc_i,
  input  logic               halt_req_i,
  input  logic               invalid_i,
  output logic               wr_en_o,
  output core_pkg::reg_idx_t wr_idx_o,
  output core_pkg::word_t    wr_data_o,
  output core_pkg::commit_s  commit_o
);

  assign wr_en_o   = exe_valid_i & rd_wr_en_i;
  assign wr_idx_o  = rd_idx_i;
  assign wr_data_o = result_i;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      commit_o.valid <= 1'b0;
    end else begin
      commit_o.valid <= exe_valid_i;
      if (exe_valid_i) begin
        commit_o.pc       <= pc_i;
        commit_o.rd_wr_en <= rd_wr_en_i;
        commit_o.rd_idx   <= rd_idx_i;
        commit_o.rd_data  <= result_i;
        commit_o.next_pc  <= next_pc_i;
        // Halt cause, EBREAK or an invalid word
        commit_o.halt     <= halt_req_i & ~invalid_i;
        commit_o.invalid  <= halt_req_i & invalid_i;
      end
    end
  end

endmodule

`default_nettype wire

//--- core_exu.sv
`timescale 1ns/1ps
`default_nettype none

module core_exu (
  input  core_pkg::fetch_s   fetch_i,
  input  core_pkg::dec_s     dec_i,
  output logic               exe_valid_o,
  output core_pkg::word_t    result_o,
  output core_pkg::word_t    next_pc_o,
  output logic               halt_req_o,
  output logic               rd_wr_en_o,
  output core_pkg::reg_idx_t rd_idx_o
);

  core_pkg::exu_info_t info;
  core_pkg::word_t     op1, op2, sum, alu_res, target;
  logic [5:0]          shamt;
  logic                is_alu, is_bjp, is_sys;
  logic                eq, lt, ltu, taken, jump;

  assign info   = dec_i.exu_info;
  assign op1    = dec_i.op1;
  assign op2    = dec_i.op2;
  assign shamt  = op2[5:0];
  assign is_alu = (info[2:0] == core_pkg::EXU_GRP_ALU);
  assign is_bjp = (info[2:0] == core_pkg::EXU_GRP_BJP);
  assign is_sys = (info[2:0] == core_pkg::EXU_GRP_SYS);

  // Shared by ADD, AUIPC and the link address
  assign sum = op1 + op2;
  assign eq  = (op1 == op2);
  assign lt  = ($signed(op1) < $signed(op2));
  assign ltu = (op1 < op2);

  always_comb begin
    case (1'b1)
      info[core_pkg::EXU_INFO_ALU_ADD]:  alu_res = sum;
      info[core_pkg::EXU_INFO_ALU_SUB]:  alu_res = op1 - op2;
      info[core_pkg::EXU_INFO_ALU_SLL]:  alu_res = op1 << shamt;
      info[core_pkg::EXU_INFO_ALU_SLT]:  alu_res = {63'd0, lt};
      info[core_pkg::EXU_INFO_ALU_SLTU]: alu_res = {63'd0, ltu};
      info[core_pkg::EXU_INFO_ALU_XOR]:  alu_res = op1 ^ op2;
      info[core_pkg::EXU_INFO_ALU_SRL]:  alu_res = op1 >> shamt;
      info[core_pkg::EXU_INFO_ALU_SRA]:  alu_res = $signed(op1) >>> shamt;
      info[core_pkg::EXU_INFO_ALU_OR]:   alu_res = op1 | op2;
      info[core_pkg::EXU_INFO_ALU_AND]:  alu_res = op1 & op2;
      info[core_pkg::EXU_INFO_ALU_LUI]:  alu_res = op2;
      default:                           alu_res = '0;
    endcase
  end

  // Branch resolution
  assign taken = (info[core_pkg::EXU_INFO_BJP_BEQ]  &  eq)  |
                 (info[core_pkg::EXU_INFO_BJP_BNE]  & ~eq)  |
                 (info[core_pkg::EXU_INFO_BJP_BLT]  &  lt)  |
                 (info[core_pkg::EXU_INFO_BJP_BGE]  & ~lt)  |
                 (info[core_pkg::EXU_INFO_BJP_BLTU] &  ltu) |
                 (info[core_pkg::EXU_INFO_BJP_BGEU] & ~ltu);
  assign jump  = info[core_pkg::EXU_INFO_BJP_JAL] | info[core_pkg::EXU_INFO_BJP_JALR];

  always_comb begin
    target = dec_i.op1_jp + dec_i.op2_jp;
    // JALR clears the low bit of the target
    if (info[core_pkg::EXU_INFO_BJP_JALR]) begin
      target[0] = 1'b0;
    end
  end

  assign next_pc_o = (is_bjp & (taken | jump)) ? target : fetch_i.pc + 64'd4;

  assign result_o = ({core_pkg::XLEN{is_alu}} & alu_res) |
                    ({core_pkg::XLEN{is_bjp}} & sum);

  assign halt_req_o  = dec_i.invalid | (is_sys & info[core_pkg::EXU_INFO_SYS_EBREAK]);
  assign exe_valid_o = fetch_i.valid;
  assign rd_wr_en_o  = dec_i.rd_wr_en & ~halt_req_o;
  assign rd_idx_o    = dec_i.rd_idx;

endmodule

`default_nettype wire

//--- core_regfile.sv
`timescale 1ns/1ps
`default_nettype none

module core_regfile (
  input  logic               clk_i,
  input  logic               rst_i,
  input  core_pkg::reg_idx_t rs1_idx_i,
  input  core_pkg::reg_idx_t rs2_idx_i,
  input  logic               rs1_read_en_i,
  input  logic               rs2_read_en_i,
  input  logic               wr_en_i,
  input  core_pkg::reg_idx_t wr_idx_i,
  input  core_pkg::word_t    wr_data_i,
  output core_pkg::word_t    rs1_data_o,
  output core_pkg::word_t    rs2_data_o
);

  // x0 has no storage
  core_pkg::word_t regs_q [1:31];

  assign rs1_data_o = (rs1_read_en_i && rs1_idx_i != '0) ? regs_q[rs1_idx_i] : '0;
  assign rs2_data_o = (rs2_read_en_i && rs2_idx_i != '0) ? regs_q[rs2_idx_i] : '0;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      for (int i = 1; i < 32; i++) begin
        regs_q[i] <= '0;
      end
    end else if (wr_en_i && wr_idx_i != '0) begin
      regs_q[wr_idx_i] <= wr_data_i;
    end
  end

endmodule

`default_nettype wire

//--- core_idu.sv
`timescale 1ns/1ps
`default_nettype none

module core_idu (
  input  core_pkg::fetch_s   fetch_i,
  input  core_pkg::word_t    rs1_data_i,
  input  core_pkg::word_t    rs2_data_i,
  output core_pkg::reg_idx_t rs1_idx_o,
  output core_pkg::reg_idx_t rs2_idx_o,
  output logic               rs1_read_en_o,
  output logic               rs2_read_en_o,
  output core_pkg::dec_s     dec_o
);

  core_pkg::inst_t    inst;
  logic [6:0]         opcode;
  logic [7:0]         f3;
  core_pkg::reg_idx_t rd;
  logic               f7_zero;
  logic               f7_alt;
  logic               sh_zero;
  logic               sh_alt;

  assign inst    = fetch_i.inst;
  assign opcode  = inst[6:0];
  assign rd      = inst[11:7];
  // One-hot funct3
  assign f3      = 8'd1 << inst[14:12];
  assign f7_zero = (inst[31:25] == 7'h00);
  assign f7_alt  = (inst[31:25] == 7'h20);
  // RV64 shift immediates keep a 6-bit shamt
  assign sh_zero = (inst[31:26] == 6'b000000);
  assign sh_alt  = (inst[31:26] == 6'b010000);

  assign rs1_idx_o = inst[19:15];
  assign rs2_idx_o = inst[24:20];

  // Opcode classes
  logic is_op, is_op_imm, is_branch, is_jal, is_jalr, is_lui, is_auipc, is_ebreak;

  assign is_op     = (opcode == core_pkg::OPC_OP);
  assign is_op_imm = (opcode == core_pkg::OPC_OP_IMM);
  assign is_branch = (opcode == core_pkg::OPC_BRANCH);
  assign is_jal    = (opcode == core_pkg::OPC_JAL);
  assign is_jalr   = (opcode == core_pkg::OPC_JALR);
  assign is_lui    = (opcode == core_pkg::OPC_LUI);
  assign is_auipc  = (opcode == core_pkg::OPC_AUIPC);
  assign is_ebreak = (inst == core_pkg::EBREAK_INST);

  logic r_base, r_alt, i_shz, i_sha;

  assign r_base = is_op & f7_zero;
  assign r_alt  = is_op & f7_alt;
  assign i_shz  = is_op_imm & sh_zero;
  assign i_sha  = is_op_imm & sh_alt;

  // ALU operations, register and immediate forms merged
  logic alu_add, alu_sub, alu_sll, alu_slt, alu_sltu, alu_xor;
  logic alu_srl, alu_sra, alu_or, alu_and, alu_lui, alu_op;

  assign alu_add  = f3[0] & (r_base | is_op_imm) | is_auipc;
  assign alu_sub  = f3[0] & r_alt;
  assign alu_sll  = f3[1] & (r_base | i_shz);
  assign alu_slt  = f3[2] & (r_base | is_op_imm);
  assign alu_sltu = f3[3] & (r_base | is_op_imm);
  assign alu_xor  = f3[4] & (r_base | is_op_imm);
  assign alu_srl  = f3[5] & (r_base | i_shz);
  assign alu_sra  = f3[5] & (r_alt | i_sha);
  assign alu_or   = f3[6] & (r_base | is_op_imm);
  assign alu_and  = f3[7] & (r_base | is_op_imm);
  assign alu_lui  = is_lui;
  assign alu_op   = alu_add | alu_sub | alu_sll | alu_slt | alu_sltu | alu_xor |
                    alu_srl | alu_sra | alu_or | alu_and | alu_lui;

  // Branches and jumps
  logic beq, bne, blt, bge, bltu, bgeu, jalr, bjp_op;

  assign beq    = is_branch & f3[0];
  assign bne    = is_branch & f3[1];
  assign blt    = is_branch & f3[4];
  assign bge    = is_branch & f3[5];
  assign bltu   = is_branch & f3[6];
  assign bgeu   = is_branch & f3[7];
  assign jalr   = is_jalr & f3[0];
  assign bjp_op = beq | bne | blt | bge | bltu | bgeu | is_jal | jalr;

  // Immediates
  core_pkg::word_t imm_i, imm_b, imm_u, imm_j, imm;

  assign imm_i = {{52{inst[31]}}, inst[31:20]};
  assign imm_b = {{52{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
  assign imm_u = {{32{inst[31]}}, inst[31:12], 12'b0};
  assign imm_j = {{44{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};

  assign imm = ({core_pkg::XLEN{is_op_imm | is_jalr}} & imm_i) |
               ({core_pkg::XLEN{is_branch}}          & imm_b) |
               ({core_pkg::XLEN{is_lui | is_auipc}}  & imm_u) |
               ({core_pkg::XLEN{is_jal}}             & imm_j);

  assign rs1_read_en_o = is_op | is_op_imm | is_branch | is_jalr;
  assign rs2_read_en_o = is_op | is_branch;

  always_comb begin
    dec_o = '0;
    dec_o.rd_idx   = rd;
    dec_o.rd_wr_en = (alu_op | is_jal | jalr) & (rd != '0);
    dec_o.invalid  = ~(alu_op | bjp_op | is_ebreak);

    // Operand sources
    if (is_op | is_op_imm | is_branch) begin
      dec_o.op1 = rs1_data_i;
    end else if (is_auipc | is_jal | is_jalr) begin
      dec_o.op1 = fetch_i.pc;
    end
    if (is_op | is_branch) begin
      dec_o.op2 = rs2_data_i;
    end else if (is_op_imm | is_lui | is_auipc) begin
      dec_o.op2 = imm;
    end else if (is_jal | is_jalr) begin
      dec_o.op2 = 64'd4;
    end
    if (is_jalr) begin
      dec_o.op1_jp = rs1_data_i;
    end else if (is_branch | is_jal) begin
      dec_o.op1_jp = fetch_i.pc;
    end
    if (is_branch | is_jal | is_jalr) begin
      dec_o.op2_jp = imm;
    end

    // Execute info, group code plus one-hot flags
    if (alu_op) begin
      dec_o.exu_info[2:0]                           = core_pkg::EXU_GRP_ALU;
      dec_o.exu_info[core_pkg::EXU_INFO_ALU_ADD]  = alu_add;
      dec_o.exu_info[core_pkg::EXU_INFO_ALU_SUB]  = alu_sub;
      dec_o.exu_info[core_pkg::EXU_INFO_ALU_SLL]  = alu_sll;
      dec_o.exu_info[core_pkg::EXU_INFO_ALU_SLT]  = alu_slt;
      dec_o.exu_info[core_pkg::EXU_INFO_ALU_SLTU] = alu_sltu;
      dec_o.exu_info[core_pkg::EXU_INFO_ALU_XOR]  = alu_xor;
      dec_o.exu_info[core_pkg::EXU_INFO_ALU_SRL]  = alu_srl;
      dec_o.exu_info[core_pkg::EXU_INFO_ALU_SRA]  = alu_sra;
      dec_o.exu_info[core_pkg::EXU_INFO_ALU_OR]   = alu_or;
      dec_o.exu_info[core_pkg::EXU_INFO_ALU_AND]  = alu_and;
      dec_o.exu_info[core_pkg::EXU_INFO_ALU_LUI]  = alu_lui;
    end else if (bjp_op) begin
      dec_o.exu_info[2:0]                           = core_pkg::EXU_GRP_BJP;
      dec_o.exu_info[core_pkg::EXU_INFO_BJP_JAL]  = is_jal;
      dec_o.exu_info[core_pkg::EXU_INFO_BJP_JALR] = jalr;
      dec_o.exu_info[core_pkg::EXU_INFO_BJP_BEQ]  = beq;
      dec_o.exu_info[core_pkg::EXU_INFO_BJP_BNE]  = bne;
      dec_o.exu_info[core_pkg::EXU_INFO_BJP_BLT]  = blt;
      dec_o.exu_info[core_pkg::EXU_INFO_BJP_BGE]  = bge;
      dec_o.exu_info[core_pkg::EXU_INFO_BJP_BLTU] = bltu;
      dec_o.exu_info[core_pkg::EXU_INFO_BJP_BGEU] = bgeu;
    end else if (is_ebreak) begin
      dec_o.exu_info[2:0]                             = core_pkg::EXU_GRP_SYS;
      dec_o.exu_info[core_pkg::EXU_INFO_SYS_EBREAK] = 1'b1;
    end
  end

endmodule

`default_nettype wire

//--- core_ifu.sv
`timescale 1ns/1ps
`default_nettype none

module core_ifu #(
  parameter core_pkg::word_t RESET_PC = '0
) (
  input  logic             clk_i,
  input  logic             rst_i,
  input  logic             inst_valid_i,
  input  core_pkg::inst_t  inst_i,
  input  logic             exe_valid_i,
  input  core_pkg::word_t  next_pc_i,
  input  logic             halt_req_i,
  output core_pkg::fetch_s fetch_o,
  output core_pkg::word_t  pc_o,
  output logic             halted_o
);

  core_pkg::run_state_e state_q;
  core_pkg::word_t      pc_q;
  logic                 halting;
  logic                 accept;

  assign halting  = exe_valid_i & halt_req_i;
  assign halted_o = (state_q == core_pkg::HALTED);

  // Resolved pc while an instruction executes, stored pc otherwise
  assign pc_o = exe_valid_i ? next_pc_i : pc_q;

  // Strobe next to a halting instruction is dropped
  assign accept = inst_valid_i & (state_q == core_pkg::RUN) & ~halting;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q       <= core_pkg::RUN;
      pc_q          <= RESET_PC;
      fetch_o.valid <= 1'b0;
    end else begin
      if (halting) begin
        state_q <= core_pkg::HALTED;
      end
      if (exe_valid_i) begin
        pc_q <= next_pc_i;
      end
      fetch_o.valid <= accept;
      // Payload only moves on an accepted strobe
      if (accept) begin
        fetch_o.pc   <= pc_o;
        fetch_o.inst <= inst_i;
      end
    end
  end

endmodule

`default_nettype wire

//--- core_pkg.sv
`default_nettype none

package core_pkg;

  localparam int XLEN       = 64;
  localparam int EXU_INFO_W = 15;

  typedef logic [XLEN-1:0]       word_t;
  typedef logic [31:0]           inst_t;
  typedef logic [4:0]            reg_idx_t;
  typedef logic [EXU_INFO_W-1:0] exu_info_t;

  // Group code in exu_info[2:0]
  localparam logic [2:0] EXU_GRP_ALU = 3'd0;
  localparam logic [2:0] EXU_GRP_BJP = 3'd1;
  localparam logic [2:0] EXU_GRP_SYS = 3'd2;

  // ALU operation flags
  localparam int EXU_INFO_ALU_ADD  = 3;
  localparam int EXU_INFO_ALU_SUB  = 4;
  localparam int EXU_INFO_ALU_SLL  = 5;
  localparam int EXU_INFO_ALU_SLT  = 6;
  localparam int EXU_INFO_ALU_SLTU = 7;
  localparam int EXU_INFO_ALU_XOR  = 8;
  localparam int EXU_INFO_ALU_SRL  = 9;
  localparam int EXU_INFO_ALU_SRA  = 10;
  localparam int EXU_INFO_ALU_OR   = 11;
  localparam int EXU_INFO_ALU_AND  = 12;
  localparam int EXU_INFO_ALU_LUI  = 13;

  // Branch and jump flags, same positions as the ALU ones
  localparam int EXU_INFO_BJP_JAL  = 3;
  localparam int EXU_INFO_BJP_JALR = 4;
  localparam int EXU_INFO_BJP_BEQ  = 5;
  localparam int EXU_INFO_BJP_BNE  = 6;
  localparam int EXU_INFO_BJP_BLT  = 7;
  localparam int EXU_INFO_BJP_BGE  = 8;
  localparam int EXU_INFO_BJP_BLTU = 9;
  localparam int EXU_INFO_BJP_BGEU = 10;

  localparam int EXU_INFO_SYS_EBREAK = 3;

  // Major opcodes
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC  = 7'b0010111;

  localparam inst_t EBREAK_INST = 32'h0010_0073;

  typedef struct packed {
    logic  valid;
    word_t pc;
    inst_t inst;
  } fetch_s;

  typedef struct packed {
    logic      rd_wr_en;
    reg_idx_t  rd_idx;
    word_t     op1;
    word_t     op2;
    word_t     op1_jp;
    word_t     op2_jp;
    exu_info_t exu_info;
    logic      invalid;
  } dec_s;

  typedef struct packed {
    logic     valid;
    word_t    pc;
    logic     rd_wr_en;
    reg_idx_t rd_idx;
    word_t    rd_data;
    word_t    next_pc;
    logic     halt;
    logic     invalid;
  } commit_s;

  typedef enum logic {
    RUN,
    HALTED
  } run_state_e;

endpackage

`default_nettype wire
